// File: dv/noc_golden.hex
// columns: src node (1), dst x (1), dst y (1), payload (4), expected node (1), idle gap (2)
// all-to-all first, then a burst from every node to node 0
000A000002
010A001102
001A002202
011A003302
100A010002
110A011102
101A012202
111A013302
200A020002
210A021102
201A022202
211A023302
300A030002
310A031102
301A032202
311A033302
000B000030
000B001000
000B002000
000B003000
000B004000
000B005000
100B010030
100B011000
100B012000
100B013000
100B014000
100B015000
200B020030
200B021000
200B022000
200B023000
200B024000
200B025000
300B030030
300B031000
300B032000
300B033000
300B034000
300B035000

// File: flist.f
source/noc_pkg.sv
source/noc_input_buffer.sv
source/noc_route_calc.sv
source/noc_switch_alloc.sv
source/noc_router.sv
source/noc_mesh.sv
dv/tb_noc_mesh.sv

// File: Makefile
# Verilator build and run for the noc mesh testbench

TOP := tb_noc_mesh

.PHONY: all compile run clean

all: run

# build the simulation executable from the file list
compile:
	verilator --binary --timing -f flist.f --top-module $(TOP) -o $(TOP)

# run from the project root so the golden file path resolves
run: compile
	./obj_dir/$(TOP) | tee sim.log
	grep -q "Simulation passed" sim.log

clean:
	rm -rf obj_dir sim.log

// File: dv/tb_noc_mesh.sv
// noc mesh testbench
// drives single-flit packets from the golden file into every node and
// checks each delivery against per-source expected queues
module tb_noc_mesh;

  localparam int MAX_ENTRIES   = 64;
  localparam int HS_TIMEOUT    = 200;
  localparam int DRAIN_TIMEOUT = 500;

  logic                          clk;
  logic                          arst_n;
  noc_pkg::flit_t                in_flit   [noc_pkg::NODES];
  logic [noc_pkg::NODES-1:0]     in_valid;
  wire  [noc_pkg::NODES-1:0]     in_ready;
  wire  noc_pkg::flit_t          out_flit  [noc_pkg::NODES];
  wire  [noc_pkg::NODES-1:0]     out_valid;
  logic [noc_pkg::NODES-1:0]     out_ready;

  // golden entries: src, dst x, dst y, payload, expected node, gap
  logic [39:0]    golden [MAX_ENTRIES];
  int             n_entries;
  // expected flits, index is receiving node * NODES + source node
  noc_pkg::flit_t exp_q [noc_pkg::NODES * noc_pkg::NODES][$];

  logic                      bp_mode = 1'b0;
  logic                      stall_seen = 1'b0;
  int                        err_count = 0;
  // last negedge saw valid without ready
  logic [noc_pkg::NODES-1:0] held = '0;
  noc_pkg::flit_t            held_flit [noc_pkg::NODES];

  noc_mesh u_noc_mesh (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_flit   (in_flit),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .out_flit  (out_flit),
    .out_valid (out_valid),
    .out_ready (out_ready)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  // flit as the source node sends it
  function automatic noc_pkg::flit_t make_flit(input int src, input logic [39:0] e);
    noc_pkg::flit_t f;
    logic [31:0]    sx;
    logic [31:0]    sy;
    sx        = src % noc_pkg::MESH_X;
    sy        = src / noc_pkg::MESH_X;
    f.dst_x   = e[32 +: noc_pkg::COORD_W];
    f.dst_y   = e[28 +: noc_pkg::COORD_W];
    f.src_x   = sx[noc_pkg::COORD_W-1:0];
    f.src_y   = sy[noc_pkg::COORD_W-1:0];
    f.payload = e[27:12];
    return f;
  endfunction

  task automatic check_equal(input logic [63:0] got, input logic [63:0] exp,
                             input string msg);
    if (got !== exp) begin
      err_count++;
      $display("Fail at time %0t: %s (got %0h, expected %0h)", $time, msg, got, exp);
      $display("Simulation failed");
      $fatal(1, "value check failed");
    end
  endtask

  task automatic report_error(input string msg);
    $display("%s, at time %0t", msg, $time);
    $display("Simulation failed");
    $fatal(1, "test aborted");
  endtask

  function automatic int pending_count();
    int total;
    total = 0;
    for (int q = 0; q < noc_pkg::NODES * noc_pkg::NODES; q++) begin
      total += exp_q[q].size();
    end
    return total;
  endfunction

  task automatic load_expected();
    int src;
    int dst;
    for (int i = 0; i < n_entries; i++) begin
      src = int'(golden[i][39:36]);
      dst = int'(golden[i][11:8]);
      exp_q[dst * noc_pkg::NODES + src].push_back(make_flit(src, golden[i]));
    end
  endtask

  // offers this node's packets in file order, entered just after a rising edge
  task automatic drive_node(input int node);
    logic [39:0] e;
    int          waited;
    logic        done;
    for (int i = 0; i < n_entries; i++) begin
      e = golden[i];
      if (int'(e[39:36]) == node) begin
        repeat (int'(e[7:0])) begin
          @(posedge clk);
          #1;
        end
        in_flit[node]  = make_flit(node, e);
        in_valid[node] = 1'b1;
        waited = 0;
        done   = 1'b0;
        // ready seen mid-cycle means the flit goes at the next edge
        while (!done) begin
          @(negedge clk);
          if (in_ready[node]) begin
            done = 1'b1;
          end else begin
            waited++;
            if (waited > HS_TIMEOUT) begin
              report_error($sformatf("node %0d never raised in_ready", node));
            end
          end
        end
        @(posedge clk);
        #1;
        in_valid[node] = 1'b0;
      end
    end
  endtask

  task automatic wait_drain();
    int cycles;
    cycles = 0;
    while (pending_count() != 0 && cycles < DRAIN_TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (pending_count() != 0) begin
      for (int q = 0; q < noc_pkg::NODES * noc_pkg::NODES; q++) begin
        for (int k = 0; k < exp_q[q].size(); k++) begin
          $display("packet with payload %h from node %0d to node %0d never arrived",
                   exp_q[q][k].payload, q % noc_pkg::NODES, q / noc_pkg::NODES);
        end
      end
      report_error("some packets were never delivered");
    end
  endtask

  // everything drained, mesh back to its reset look
  task automatic check_idle();
    @(negedge clk);
    check_equal(64'(out_valid), 64'd0, "out_valid still high after drain");
    check_equal(64'(&in_ready), 64'd1, "in_ready low on an idle node");
  endtask

  // out_ready per node, all high or one lfsr bit each
  initial begin
    logic [31:0] lfsr;
    lfsr      = 32'hdafd;
    out_ready = '1;
    forever begin
      @(posedge clk);
      #1;
      if (bp_mode) begin
        for (int n = 0; n < noc_pkg::NODES; n++) begin
          lfsr         = lfsr_next(lfsr);
          out_ready[n] = lfsr[0];
        end
      end else begin
        out_ready = '1;
      end
    end
  end

  // monitor, mid-cycle when every input and output is settled
  always @(negedge clk) begin
    int             s;
    noc_pkg::flit_t exp_f;
    if (arst_n) begin
      for (int d = 0; d < noc_pkg::NODES; d++) begin
        if (held[d]) begin
          check_equal(64'(out_valid[d]), 64'd1,
                      $sformatf("node %0d dropped out_valid while stalled", d));
          check_equal(64'(out_flit[d]), 64'(held_flit[d]),
                      $sformatf("node %0d changed out_flit while stalled", d));
        end
        held[d]      = out_valid[d] && !out_ready[d];
        held_flit[d] = out_flit[d];
        if (out_valid[d] && out_ready[d]) begin
          s = int'(out_flit[d].src_y) * noc_pkg::MESH_X + int'(out_flit[d].src_x);
          check_equal(64'(exp_q[d * noc_pkg::NODES + s].size() != 0), 64'd1,
                      $sformatf("unexpected flit at node %0d from node %0d", d, s));
          exp_f = exp_q[d * noc_pkg::NODES + s].pop_front();
          check_equal(64'(out_flit[d]), 64'(exp_f),
                      $sformatf("wrong flit at node %0d from node %0d", d, s));
        end
        if (in_valid[d] && !in_ready[d]) begin
          stall_seen = 1'b1;
        end
      end
    end
  end

  initial begin
    arst_n   = 1'b0;
    in_valid = '0;
    for (int n = 0; n < noc_pkg::NODES; n++) begin
      in_flit[n] = '0;
    end
    for (int i = 0; i < MAX_ENTRIES; i++) begin
      golden[i] = '1;
    end
    $readmemh("dv/noc_golden.hex", golden);
    n_entries = 0;
    while (n_entries < MAX_ENTRIES && golden[n_entries][39:36] != 4'hf) begin
      n_entries++;
    end
    if (n_entries == 0) begin
      report_error("golden file holds no packets");
    end

    repeat (10) @(posedge clk);
    #1;
    arst_n = 1'b1;

    // quiet mesh after reset
    @(negedge clk);
    check_equal(64'(&in_ready), 64'd1, "in_ready low after reset");
    repeat (20) begin
      @(negedge clk);
      check_equal(64'(out_valid), 64'd0, "out_valid high with no input");
    end

    // first pass with free outputs, second with lfsr back-pressure
    for (int pass = 0; pass < 2; pass++) begin
      bp_mode = (pass == 1);
      load_expected();
      @(posedge clk);
      #1;
      // one driver per node of the 2x2 mesh
      fork
        drive_node(0);
        drive_node(1);
        drive_node(2);
        drive_node(3);
      join
      wait_drain();
      check_idle();
    end

    // the burst to node 0 must have pushed back on its sources
    check_equal(64'(stall_seen), 64'd1, "in_ready never dropped under contention");

    if (err_count == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: source/noc_mesh.sv
// noc mesh top
// grid of routers with neighbour links, mesh-edge ports tied off
// and local ports brought out per node
module noc_mesh (
  input  logic                        clk,
  input  logic                        arst_n,
  input  noc_pkg::flit_t              in_flit   [noc_pkg::NODES],
  input  logic [noc_pkg::NODES-1:0]   in_valid,
  output wire  [noc_pkg::NODES-1:0]   in_ready,
  output wire  noc_pkg::flit_t        out_flit  [noc_pkg::NODES],
  output wire  [noc_pkg::NODES-1:0]   out_valid,
  input  logic [noc_pkg::NODES-1:0]   out_ready
);

  // per router, per port link wires
  wire noc_pkg::flit_t         r_in_flit   [noc_pkg::NODES][noc_pkg::PORTS];
  wire [noc_pkg::PORTS-1:0]    r_in_valid  [noc_pkg::NODES];
  wire [noc_pkg::PORTS-1:0]    r_in_ready  [noc_pkg::NODES];
  wire noc_pkg::flit_t         r_out_flit  [noc_pkg::NODES][noc_pkg::PORTS];
  wire [noc_pkg::PORTS-1:0]    r_out_valid [noc_pkg::NODES];
  wire [noc_pkg::PORTS-1:0]    r_out_ready [noc_pkg::NODES];

  genvar x, y;
  generate
    for (y = 0; y < noc_pkg::MESH_Y; y++) begin : g_row
      for (x = 0; x < noc_pkg::MESH_X; x++) begin : g_col

        noc_router #(
          .router_x (x),
          .router_y (y)
        ) u_router (
          .clk       (clk),
          .arst_n    (arst_n),
          .in_flit   (r_in_flit[noc_pkg::node_idx(x, y)]),
          .in_valid  (r_in_valid[noc_pkg::node_idx(x, y)]),
          .in_ready  (r_in_ready[noc_pkg::node_idx(x, y)]),
          .out_flit  (r_out_flit[noc_pkg::node_idx(x, y)]),
          .out_valid (r_out_valid[noc_pkg::node_idx(x, y)]),
          .out_ready (r_out_ready[noc_pkg::node_idx(x, y)])
        );

        // local port to the top level
        assign r_in_flit[noc_pkg::node_idx(x, y)][noc_pkg::port_local]   = in_flit[noc_pkg::node_idx(x, y)];
        assign r_in_valid[noc_pkg::node_idx(x, y)][noc_pkg::port_local]  = in_valid[noc_pkg::node_idx(x, y)];
        assign in_ready[noc_pkg::node_idx(x, y)]  = r_in_ready[noc_pkg::node_idx(x, y)][noc_pkg::port_local];
        assign out_flit[noc_pkg::node_idx(x, y)]  = r_out_flit[noc_pkg::node_idx(x, y)][noc_pkg::port_local];
        assign out_valid[noc_pkg::node_idx(x, y)] = r_out_valid[noc_pkg::node_idx(x, y)][noc_pkg::port_local];
        assign r_out_ready[noc_pkg::node_idx(x, y)][noc_pkg::port_local] = out_ready[noc_pkg::node_idx(x, y)];

        // west side, fed by the east output of x-1
        if (x > 0) begin : g_west_link
          assign r_in_flit[noc_pkg::node_idx(x, y)][noc_pkg::port_west]   = r_out_flit[noc_pkg::node_idx(x - 1, y)][noc_pkg::port_east];
          assign r_in_valid[noc_pkg::node_idx(x, y)][noc_pkg::port_west]  = r_out_valid[noc_pkg::node_idx(x - 1, y)][noc_pkg::port_east];
          assign r_out_ready[noc_pkg::node_idx(x, y)][noc_pkg::port_west] = r_in_ready[noc_pkg::node_idx(x - 1, y)][noc_pkg::port_east];
        end else begin : g_west_edge
          // XY never routes off the mesh, edge stays idle
          assign r_in_flit[noc_pkg::node_idx(x, y)][noc_pkg::port_west]   = '0;
          assign r_in_valid[noc_pkg::node_idx(x, y)][noc_pkg::port_west]  = 1'b0;
          assign r_out_ready[noc_pkg::node_idx(x, y)][noc_pkg::port_west] = 1'b0;
        end

        // east side, fed by the west output of x+1
        if (x < noc_pkg::MESH_X - 1) begin : g_east_link
          assign r_in_flit[noc_pkg::node_idx(x, y)][noc_pkg::port_east]   = r_out_flit[noc_pkg::node_idx(x + 1, y)][noc_pkg::port_west];
          assign r_in_valid[noc_pkg::node_idx(x, y)][noc_pkg::port_east]  = r_out_valid[noc_pkg::node_idx(x + 1, y)][noc_pkg::port_west];
          assign r_out_ready[noc_pkg::node_idx(x, y)][noc_pkg::port_east] = r_in_ready[noc_pkg::node_idx(x + 1, y)][noc_pkg::port_west];
        end else begin : g_east_edge
          assign r_in_flit[noc_pkg::node_idx(x, y)][noc_pkg::port_east]   = '0;
          assign r_in_valid[noc_pkg::node_idx(x, y)][noc_pkg::port_east]  = 1'b0;
          assign r_out_ready[noc_pkg::node_idx(x, y)][noc_pkg::port_east] = 1'b0;
        end

        // north side, fed by the south output of y-1
        if (y > 0) begin : g_north_link
          assign r_in_flit[noc_pkg::node_idx(x, y)][noc_pkg::port_north]   = r_out_flit[noc_pkg::node_idx(x, y - 1)][noc_pkg::port_south];
          assign r_in_valid[noc_pkg::node_idx(x, y)][noc_pkg::port_north]  = r_out_valid[noc_pkg::node_idx(x, y - 1)][noc_pkg::port_south];
          assign r_out_ready[noc_pkg::node_idx(x, y)][noc_pkg::port_north] = r_in_ready[noc_pkg::node_idx(x, y - 1)][noc_pkg::port_south];
        end else begin : g_north_edge
          assign r_in_flit[noc_pkg::node_idx(x, y)][noc_pkg::port_north]   = '0;
          assign r_in_valid[noc_pkg::node_idx(x, y)][noc_pkg::port_north]  = 1'b0;
          assign r_out_ready[noc_pkg::node_idx(x, y)][noc_pkg::port_north] = 1'b0;
        end

        // south side, fed by the north output of y+1
        if (y < noc_pkg::MESH_Y - 1) begin : g_south_link
          assign r_in_flit[noc_pkg::node_idx(x, y)][noc_pkg::port_south]   = r_out_flit[noc_pkg::node_idx(x, y + 1)][noc_pkg::port_north];
          assign r_in_valid[noc_pkg::node_idx(x, y)][noc_pkg::port_south]  = r_out_valid[noc_pkg::node_idx(x, y + 1)][noc_pkg::port_north];
          assign r_out_ready[noc_pkg::node_idx(x, y)][noc_pkg::port_south] = r_in_ready[noc_pkg::node_idx(x, y + 1)][noc_pkg::port_north];
        end else begin : g_south_edge
          assign r_in_flit[noc_pkg::node_idx(x, y)][noc_pkg::port_south]   = '0;
          assign r_in_valid[noc_pkg::node_idx(x, y)][noc_pkg::port_south]  = 1'b0;
          assign r_out_ready[noc_pkg::node_idx(x, y)][noc_pkg::port_south] = 1'b0;
        end

      end
    end
  endgenerate

endmodule

// File: source/noc_router.sv
// noc router
// five-port router: input buffer and route stage per port, one
// shared switch allocator driving the registered outputs
module noc_router #(
  parameter int router_x = 0,
  parameter int router_y = 0
) (
  input  logic                        clk,
  input  logic                        arst_n,
  input  noc_pkg::flit_t              in_flit   [noc_pkg::PORTS],
  input  logic [noc_pkg::PORTS-1:0]   in_valid,
  output wire  [noc_pkg::PORTS-1:0]   in_ready,
  output noc_pkg::flit_t              out_flit  [noc_pkg::PORTS],
  output logic [noc_pkg::PORTS-1:0]   out_valid,
  input  logic [noc_pkg::PORTS-1:0]   out_ready
);

  // buffer to route stage
  wire noc_pkg::flit_t             buf_flit  [noc_pkg::PORTS];
  wire [noc_pkg::PORTS-1:0]        buf_valid;
  wire [noc_pkg::PORTS-1:0]        buf_ready;

  // route stage to switch
  wire noc_pkg::route_t            rc_route  [noc_pkg::PORTS];
  wire [noc_pkg::PORTS-1:0]        rc_valid;
  logic [noc_pkg::PORTS-1:0]       sw_grant;

  genvar p;
  generate
    // one buffer and one route stage per port, indexed by port_e
    for (p = 0; p < noc_pkg::PORTS; p++) begin : g_port
      noc_input_buffer u_input_buffer (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_flit   (in_flit[p]),
        .in_valid  (in_valid[p]),
        .in_ready  (in_ready[p]),
        .out_flit  (buf_flit[p]),
        .out_valid (buf_valid[p]),
        .out_ready (buf_ready[p])
      );

      // grant doubles as ready of the route register
      noc_route_calc #(
        .router_x (router_x),
        .router_y (router_y)
      ) u_route_calc (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_flit   (buf_flit[p]),
        .in_valid  (buf_valid[p]),
        .in_ready  (buf_ready[p]),
        .out_route (rc_route[p]),
        .out_valid (rc_valid[p]),
        .grant     (sw_grant[p])
      );
    end
  endgenerate

  // crossbar and output registers
  noc_switch_alloc u_switch_alloc (
    .clk       (clk),
    .arst_n    (arst_n),
    .req_route (rc_route),
    .req_valid (rc_valid),
    .grant     (sw_grant),
    .out_flit  (out_flit),
    .out_valid (out_valid),
    .out_ready (out_ready)
  );

endmodule

// File: source/noc_switch_alloc.sv
// noc switch allocator
// round-robin arbiter per output port, winning flit held in an
// output register until the downstream link takes it
module noc_switch_alloc (
  input  logic                        clk,
  input  logic                        arst_n,
  input  noc_pkg::route_t             req_route [noc_pkg::PORTS],
  input  logic [noc_pkg::PORTS-1:0]   req_valid,
  output logic [noc_pkg::PORTS-1:0]   grant,
  output noc_pkg::flit_t              out_flit  [noc_pkg::PORTS],
  output logic [noc_pkg::PORTS-1:0]   out_valid,
  input  logic [noc_pkg::PORTS-1:0]   out_ready
);

  // round-robin start point per output
  logic [noc_pkg::PORT_W-1:0] rr_ptr  [noc_pkg::PORTS];

  // arbitration result per output
  logic [noc_pkg::PORT_W-1:0] win_idx [noc_pkg::PORTS];
  logic [noc_pkg::PORTS-1:0]  win_valid;

  // output register empty or draining this cycle
  logic [noc_pkg::PORTS-1:0]  out_free;

  // arbitration
  always_comb begin
    int idx;
    grant = '0;
    for (int o = 0; o < noc_pkg::PORTS; o++) begin
      win_valid[o] = 1'b0;
      win_idx[o]   = '0;
      out_free[o]  = !out_valid[o] || out_ready[o];
      // scan inputs starting at the pointer, first match wins
      for (int k = 0; k < noc_pkg::PORTS; k++) begin
        idx = (int'(rr_ptr[o]) + k) % noc_pkg::PORTS;
        if (!win_valid[o] && req_valid[idx] &&
            req_route[idx].out_port == noc_pkg::port_e'(o)) begin
          win_valid[o] = 1'b1;
          win_idx[o]   = idx[noc_pkg::PORT_W-1:0];
        end
      end
      // an input asks for one output only, so grants never collide
      if (win_valid[o] && out_free[o]) begin
        grant[win_idx[o]] = 1'b1;
      end
    end
  end

  // output valid and pointer update
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      out_valid <= '0;
      for (int o = 0; o < noc_pkg::PORTS; o++) begin
        rr_ptr[o] <= '0;
      end
    end else begin
      for (int o = 0; o < noc_pkg::PORTS; o++) begin
        if (win_valid[o] && out_free[o]) begin
          out_valid[o] <= 1'b1;
          // next search starts just past the winner
          rr_ptr[o] <= (win_idx[o] == noc_pkg::PORT_LAST) ? '0 : win_idx[o] + 1'b1;
        end else if (out_ready[o]) begin
          out_valid[o] <= 1'b0;
        end
      end
    end
  end

  // winning flit into the output register
  always_ff @(posedge clk) begin
    for (int o = 0; o < noc_pkg::PORTS; o++) begin
      if (win_valid[o] && out_free[o]) begin
        out_flit[o] <= req_route[win_idx[o]].flit;
      end
    end
  end

endmodule

// File: source/noc_route_calc.sv
// noc route stage
// registers the head flit of one input together with its XY output port
module noc_route_calc #(
  parameter int router_x = 0,
  parameter int router_y = 0
) (
  input  logic            clk,
  input  logic            arst_n,
  input  noc_pkg::flit_t  in_flit,
  input  logic            in_valid,
  output logic            in_ready,
  output noc_pkg::route_t out_route,
  output logic            out_valid,
  input  logic            grant
);

  noc_pkg::route_t route_q;
  noc_pkg::port_e  next_port;
  logic            valid_q;
  logic            load;

  // dimension order: x first, then y, then local
  // y grows toward south
  always_comb begin
    if (int'(in_flit.dst_x) > router_x) begin
      next_port = noc_pkg::port_east;
    end else if (int'(in_flit.dst_x) < router_x) begin
      next_port = noc_pkg::port_west;
    end else if (int'(in_flit.dst_y) > router_y) begin
      next_port = noc_pkg::port_south;
    end else if (int'(in_flit.dst_y) < router_y) begin
      next_port = noc_pkg::port_north;
    end else begin
      next_port = noc_pkg::port_local;
    end
  end

  // empty or leaving this cycle, no bubble on back-to-back flits
  assign in_ready = !valid_q || grant;
  assign load     = in_valid && in_ready;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      valid_q <= 1'b0;
    end else if (load) begin
      valid_q <= 1'b1;
    end else if (grant) begin
      valid_q <= 1'b0;
    end
  end

  // decision held until the switch grants it
  always_ff @(posedge clk) begin
    if (load) begin
      route_q.flit     <= in_flit;
      route_q.out_port <= next_port;
    end
  end

  assign out_route = route_q;
  assign out_valid = valid_q;

endmodule

// File: source/noc_input_buffer.sv
// noc input buffer
// small circular FIFO in front of each router input, presents the
// oldest flit to the route stage
module noc_input_buffer (
  input  logic           clk,
  input  logic           arst_n,
  input  noc_pkg::flit_t in_flit,
  input  logic           in_valid,
  output logic           in_ready,
  output noc_pkg::flit_t out_flit,
  output logic           out_valid,
  input  logic           out_ready
);

  // storage
  noc_pkg::flit_t mem [noc_pkg::FIFO_DEPTH];

  // pointers and fill level
  logic [noc_pkg::PTR_W-1:0] wr_ptr;
  logic [noc_pkg::PTR_W-1:0] rd_ptr;
  logic [noc_pkg::CNT_W-1:0] count;

  logic push;
  logic pop;

  // ready depends on fill level only
  // so the ready chain stops here instead of running through the mesh
  assign in_ready  = (count != noc_pkg::FULL_COUNT);
  assign out_valid = (count != '0);
  assign out_flit  = mem[rd_ptr];

  assign push = in_valid && in_ready;
  assign pop  = out_valid && out_ready;

  // pointer and count update
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        // wrap at the last slot, depth need not be a power of two
        wr_ptr <= (wr_ptr == noc_pkg::PTR_LAST) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == noc_pkg::PTR_LAST) ? '0 : rd_ptr + 1'b1;
      end
      // push and pop together leave the level unchanged
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // flit storage
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_flit;
    end
  end

endmodule

// File: source/noc_pkg.sv
// noc package
// mesh geometry, flit layout and router port encoding shared by
// the routers, the mesh top and the testbench
package noc_pkg;

  // mesh geometry
  localparam int MESH_X = 2;
  localparam int MESH_Y = 2;
  localparam int NODES  = MESH_X * MESH_Y;

  // one bit per coordinate is enough for a 2x2 grid
  localparam int COORD_W   = 1;
  localparam int PAYLOAD_W = 16;

  // input buffer sizing
  localparam int FIFO_DEPTH = 2;
  localparam int PTR_W      = $clog2(FIFO_DEPTH);
  localparam int CNT_W      = $clog2(FIFO_DEPTH + 1);

  // last pointer slot and full level, sized for direct compare
  localparam logic [PTR_W-1:0] PTR_LAST   = PTR_W'(FIFO_DEPTH - 1);
  localparam logic [CNT_W-1:0] FULL_COUNT = CNT_W'(FIFO_DEPTH);

  // router ports
  localparam int PORTS  = 5;
  localparam int PORT_W = 3;

  // highest port number, wrap point of the round-robin pointers
  localparam logic [PORT_W-1:0] PORT_LAST = PORT_W'(PORTS - 1);

  // port order doubles as array index inside the router
  typedef enum logic [PORT_W-1:0] {
    port_local = 3'd0,
    port_north = 3'd1,
    port_south = 3'd2,
    port_west  = 3'd3,
    port_east  = 3'd4
  } port_e;

  // single-flit packet, header travels with every flit
  typedef struct packed {
    logic [COORD_W-1:0]   dst_x;
    logic [COORD_W-1:0]   dst_y;
    logic [COORD_W-1:0]   src_x;
    logic [COORD_W-1:0]   src_y;
    logic [PAYLOAD_W-1:0] payload;
  } flit_t;

  // flit plus the output picked by the route stage
  typedef struct packed {
    flit_t flit;
    port_e out_port;
  } route_t;

  // node numbering, row major
  function automatic int node_idx(int x, int y);
    return y * MESH_X + x;
  endfunction

endpackage
